// ==== common/bw_monitor_pkg.sv ====
package bw_monitor_pkg;

    // ---------------------------------------------------------
    // Window and count sizes
    // ---------------------------------------------------------

    // Number of cycles in the bandwidth window
    // Kept small so a few windows run quickly in simulation
    localparam int WINDOW_SIZE = 64;

    // Width of the window counter
    localparam int WIN_CNT_W = $clog2(WINDOW_SIZE);

    // Bandwidth count width
    // One extra bit so a fully busy window of WINDOW_SIZE beats fits
    localparam int BW_W = WIN_CNT_W + 1;

    // ---------------------------------------------------------
    // Types
    // ---------------------------------------------------------

    // Unsigned beat count over one window
    typedef logic [BW_W-1:0] bw_count_t;

    // One accepted beat per channel per cycle, already qualified by valid and ready
    typedef struct packed {
        logic rd;
        logic wr;
    } beat_pair_t;

    // Statistics reported for one channel
    typedef struct packed {
        bw_count_t cur;
        bw_count_t max;
        bw_count_t min;
    } bw_stats_t;

    // ---------------------------------------------------------
    // Constants in count format
    // ---------------------------------------------------------

    // Minimum after a clear, so the first tracked count always wins
    localparam bw_count_t BW_MIN_IDLE = '1;

    // Window counter value once a full window has passed
    localparam bw_count_t WINDOW_FULL = bw_count_t'(WINDOW_SIZE);

endpackage

// ==== rtl/bw_control.sv ====
`timescale 1ns/1ns

module bw_control
(
    input  logic i_clk,
    input  logic i_reset_n,

    // Command strobes, one cycle each
    input  logic i_start,
    input  logic i_stop,
    input  logic i_counter_reset,

    // Controls for the datapath
    output logic o_running,
    output logic o_clear,
    output logic o_window_done,
    output logic o_track_en
);

    // Registered command strobes
    logic start_q;
    logic stop_q;
    logic clear_q;

    // Running flag
    logic running_q;

    // Running cycles since the last clear, saturating at a full window
    bw_monitor_pkg::bw_count_t win_cnt;

    // ---------------------------------------------------------
    // Command strobe registers
    // ---------------------------------------------------------

    // A strobe sampled at one edge acts on the next edge
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            start_q <= 1'b0;
            stop_q  <= 1'b0;
            clear_q <= 1'b0;
        end
        else
        begin
            start_q <= i_start;
            stop_q  <= i_stop;
            clear_q <= i_counter_reset;
        end
    end

    // ---------------------------------------------------------
    // Running state
    // ---------------------------------------------------------

    // Stop has priority if both strobes arrive together
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            running_q <= 1'b0;
        else if (stop_q)
            running_q <= 1'b0;
        else if (start_q)
            running_q <= 1'b1;
    end

    // ---------------------------------------------------------
    // Window counter
    // ---------------------------------------------------------

    // Counts running edges only, so a stop pauses the window
    // Holds at WINDOW_FULL until the next clear
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || clear_q)
            win_cnt <= '0;
        else if (running_q && (win_cnt != bw_monitor_pkg::WINDOW_FULL))
            win_cnt <= win_cnt + bw_monitor_pkg::bw_count_t'(1);
    end

    // Outputs
    assign o_running     = running_q;
    assign o_clear       = clear_q;
    // Cur holds a full window of beats from here on
    assign o_window_done = (win_cnt == bw_monitor_pkg::WINDOW_FULL);
    // Max and min only follow cur over full windows while measuring
    assign o_track_en    = o_window_done && running_q;

endmodule

// ==== window/beat_window.sv ====
`timescale 1ns/1ns

module beat_window
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,

    // From control
    input  logic                        i_running,
    input  logic                        i_clear,

    // Beats accepted this cycle
    input  bw_monitor_pkg::beat_pair_t  i_beats,

    // Beats that leave the window this cycle
    output bw_monitor_pkg::beat_pair_t  o_expired
);

    // ---------------------------------------------------------
    // Delay line
    // ---------------------------------------------------------

    // Slot 0 holds the newest beat pair, the last slot the oldest
    bw_monitor_pkg::beat_pair_t slots [bw_monitor_pkg::WINDOW_SIZE];

    // Empty slots read as no beat, so the output needs no valid or read enable
    // A pair captured at edge N sits in the last slot after WINDOW_SIZE-1 more
    // running edges, and the channel retires it at the WINDOW_SIZE-th one
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_clear)
        begin
            for (int i = 0; i < bw_monitor_pkg::WINDOW_SIZE; i++)
            begin
                slots[i] <= '0;
            end
        end
        else if (i_running)
        begin
            slots[0] <= i_beats;
            // Shift toward the old end
            for (int i = 1; i < bw_monitor_pkg::WINDOW_SIZE; i++)
            begin
                slots[i] <= slots[i-1];
            end
        end
        // Not running, contents are held
    end

    // Oldest pair, retired by the channels on the next running edge
    assign o_expired = slots[bw_monitor_pkg::WINDOW_SIZE-1];

endmodule

// ==== rtl/bw_channel.sv ====
`timescale 1ns/1ns

module bw_channel
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,

    // From control
    input  logic                        i_running,
    input  logic                        i_clear,
    input  logic                        i_track_en,

    // Beat entering the window and beat leaving it
    input  logic                        i_new_beat,
    input  logic                        i_old_beat,

    // Current, maximum and minimum count
    output bw_monitor_pkg::bw_stats_t   o_stats
);

    // Step applied to the running count
    bw_monitor_pkg::bw_count_t step;

    // Next value of the running count
    bw_monitor_pkg::bw_count_t cur_next;

    // Statistic registers
    bw_monitor_pkg::bw_count_t cur_q;
    bw_monitor_pkg::bw_count_t max_q;
    bw_monitor_pkg::bw_count_t min_q;

    // ---------------------------------------------------------
    // Window count
    // ---------------------------------------------------------

    // Plus one for an arriving beat, minus one for an expiring beat
    // All ones adds as minus one in count width
    always_comb
    begin
        case ({i_new_beat, i_old_beat})
            2'b10:   step = bw_monitor_pkg::bw_count_t'(1);
            2'b01:   step = '1;
            default: step = '0;
        endcase
    end

    assign cur_next = cur_q + step;

    // Cur never goes below zero, since every expiring beat was counted on entry
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_clear)
            cur_q <= '0;
        else if (i_running)
            cur_q <= cur_next;
    end

    // ---------------------------------------------------------
    // Maximum and minimum tracking
    // ---------------------------------------------------------

    // Only full windows count, so tracking waits for window done
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_clear)
        begin
            max_q <= '0;
            min_q <= bw_monitor_pkg::BW_MIN_IDLE;
        end
        else if (i_track_en)
        begin
            if (cur_q > max_q)
                max_q <= cur_q;
            if (cur_q < min_q)
                min_q <= cur_q;
        end
    end

    // Report at full width
    always_comb
    begin
        o_stats.cur = cur_q;
        o_stats.max = max_q;
        o_stats.min = min_q;
    end

endmodule

// ==== rtl/bw_monitor_top.sv ====
`timescale 1ns/1ns

module bw_monitor_top
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,

    // Command strobes
    input  logic                        i_start,
    input  logic                        i_stop,
    input  logic                        i_counter_reset,

    // Accepted beats on both channels, sampled every cycle
    input  bw_monitor_pkg::beat_pair_t  i_beats,

    // Per-channel statistics
    output bw_monitor_pkg::bw_stats_t   o_rd_stats,
    output bw_monitor_pkg::bw_stats_t   o_wr_stats,

    // Status
    output logic                        o_running,
    output logic                        o_window_done
);

    // Controls shared by the datapath
    logic running;
    logic clear;
    logic window_done;
    logic track_en;

    // Pair leaving the window this cycle
    bw_monitor_pkg::beat_pair_t expired;

    // ---------------------------------------------------------
    // Control
    // ---------------------------------------------------------

    bw_control u_control
    (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_start         (i_start),
        .i_stop          (i_stop),
        .i_counter_reset (i_counter_reset),
        .o_running       (running),
        .o_clear         (clear),
        .o_window_done   (window_done),
        .o_track_en      (track_en)
    );

    // ---------------------------------------------------------
    // Datapath
    // ---------------------------------------------------------

    // One delay line carries both channels
    beat_window u_window
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_running (running),
        .i_clear   (clear),
        .i_beats   (i_beats),
        .o_expired (expired)
    );

    // Read channel
    bw_channel u_rd_channel
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_running  (running),
        .i_clear    (clear),
        .i_track_en (track_en),
        .i_new_beat (i_beats.rd),
        .i_old_beat (expired.rd),
        .o_stats    (o_rd_stats)
    );

    // Write channel
    bw_channel u_wr_channel
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_running  (running),
        .i_clear    (clear),
        .i_track_en (track_en),
        .i_new_beat (i_beats.wr),
        .i_old_beat (expired.wr),
        .o_stats    (o_wr_stats)
    );

    assign o_running     = running;
    assign o_window_done = window_done;

endmodule

// ==== verif/bw_monitor_sva.sv ====
`timescale 1ns/1ns

module bw_monitor_sva
(
    input logic                       i_clk,
    input logic                       i_reset_n,
    input logic                       i_clear,
    input logic                       i_track_en,
    input logic                       i_running,
    input logic                       i_window_done,
    input bw_monitor_pkg::bw_stats_t  i_rd_stats,
    input bw_monitor_pkg::bw_stats_t  i_wr_stats
);

    // Cur counts beats of one window, bounded by its length
    a_cur_bound: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_rd_stats.cur <= bw_monitor_pkg::WINDOW_FULL) &&
        (i_wr_stats.cur <= bw_monitor_pkg::WINDOW_FULL))
        else $error("cur count above window size");

    // Clear pulse restores the idle max and min
    a_clear_idle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_clear |=> (i_rd_stats.max == '0) && (i_wr_stats.max == '0) &&
                    (i_rd_stats.min == bw_monitor_pkg::BW_MIN_IDLE) &&
                    (i_wr_stats.min == bw_monitor_pkg::BW_MIN_IDLE))
        else $error("max or min not idle after counter reset");

    // Window completes only through running cycles
    a_done_running: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $rose(i_window_done) |-> $past(i_running))
        else $error("window done rose without a running cycle");

    // Once tracked, min stays at or below max
    a_min_max: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_window_done && $past(i_track_en)) |->
            (i_rd_stats.min <= i_rd_stats.max) && (i_wr_stats.min <= i_wr_stats.max))
        else $error("min above max with a complete window");

endmodule

bind bw_monitor_top bw_monitor_sva u_sva
(
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_clear       (clear),
    .i_track_en    (track_en),
    .i_running     (o_running),
    .i_window_done (o_window_done),
    .i_rd_stats    (o_rd_stats),
    .i_wr_stats    (o_wr_stats)
);

// ==== verif/bw_monitor_tb.sv ====
`timescale 1ns/1ns

module bw_monitor_tb;

    // Command issued at the start of a phase
    typedef enum logic [1:0] {CMD_NONE, CMD_START, CMD_STOP, CMD_CLEAR} cmd_e;

    // One phase of the stimulus table
    typedef struct packed {
        cmd_e                       cmd;
        int                         rd_period;
        int                         wr_period;
        int                         cycles;
        bw_monitor_pkg::bw_stats_t  exp_rd;
        bw_monitor_pkg::bw_stats_t  exp_wr;
        logic                       exp_running;
        logic                       exp_done;
    } row_t;

    // DUT ports
    logic                       i_clk;
    logic                       i_reset_n;
    logic                       i_start;
    logic                       i_stop;
    logic                       i_counter_reset;
    bw_monitor_pkg::beat_pair_t i_beats;
    bw_monitor_pkg::bw_stats_t  o_rd_stats;
    bw_monitor_pkg::bw_stats_t  o_wr_stats;
    logic                       o_running;
    logic                       o_window_done;

    // Stimulus table and row labels
    row_t  rows [$];
    string names [$];

    // Beat pattern, a beat whenever the free cycle count hits a multiple of the period
    // Powers of two keep slower patterns a subset of faster ones
    int pat_cnt;
    int rd_period;
    int wr_period;

    // Result counters
    int errors;
    int failed_rows;
    bit timed_out;

    bw_monitor_top u_dut
    (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_start         (i_start),
        .i_stop          (i_stop),
        .i_counter_reset (i_counter_reset),
        .i_beats         (i_beats),
        .o_rd_stats      (o_rd_stats),
        .o_wr_stats      (o_wr_stats),
        .o_running       (o_running),
        .o_window_done   (o_window_done)
    );

    // 4 ns clock
    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    // ---------------------------------------------------------
    // Expected values
    // ---------------------------------------------------------

    // Steady-state count is the number of beats in one window
    function automatic int window_beats(int period);
        if (period == 0)
            return 0;
        return bw_monitor_pkg::WINDOW_SIZE / period;
    endfunction

    function automatic bw_monitor_pkg::bw_stats_t make_stats(int cur_v, int max_v, int min_v);
        bw_monitor_pkg::bw_stats_t s;
        s.cur = bw_monitor_pkg::bw_count_t'(cur_v);
        s.max = bw_monitor_pkg::bw_count_t'(max_v);
        s.min = bw_monitor_pkg::bw_count_t'(min_v);
        return s;
    endfunction

    task automatic add_row(string name, cmd_e cmd, int rd_p, int wr_p, int cycles,
                           bw_monitor_pkg::bw_stats_t exp_rd,
                           bw_monitor_pkg::bw_stats_t exp_wr,
                           logic exp_running, logic exp_done);
        row_t r;
        r.cmd         = cmd;
        r.rd_period   = rd_p;
        r.wr_period   = wr_p;
        r.cycles      = cycles;
        r.exp_rd      = exp_rd;
        r.exp_wr      = exp_wr;
        r.exp_running = exp_running;
        r.exp_done    = exp_done;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic load_table();
        bw_monitor_pkg::bw_stats_t idle;
        bw_monitor_pkg::bw_stats_t rd_slow;
        bw_monitor_pkg::bw_stats_t wr_mid;
        int win;
        win     = bw_monitor_pkg::WINDOW_SIZE;
        idle    = make_stats(0, 0, int'(bw_monitor_pkg::BW_MIN_IDLE));
        // Max keeps the old fast rate, cur and min follow the slow one
        rd_slow = make_stats(window_beats(8), window_beats(2), window_beats(8));
        wr_mid  = make_stats(window_beats(4), window_beats(4), window_beats(4));
        add_row("idle", CMD_NONE, 1, 1, 32, idle, idle, 1'b0, 1'b0);
        add_row("constant rates", CMD_START, 2, 4, 3 * win,
                make_stats(window_beats(2), window_beats(2), window_beats(2)),
                wr_mid, 1'b1, 1'b1);
        add_row("rate change", CMD_NONE, 8, 4, 3 * win, rd_slow, wr_mid, 1'b1, 1'b1);
        add_row("stop holds", CMD_STOP, 1, 2, 2 * win, rd_slow, wr_mid, 1'b0, 1'b1);
        add_row("counter reset", CMD_CLEAR, 0, 0, 16, idle, idle, 1'b0, 1'b0);
        add_row("restart", CMD_START, 0, 1, 3 * win, make_stats(0, 0, 0),
                make_stats(window_beats(1), window_beats(1), window_beats(1)), 1'b1, 1'b1);
    endtask

    // ---------------------------------------------------------
    // Drivers and waits
    // ---------------------------------------------------------

    task automatic apply_beats();
        i_beats.rd = (rd_period != 0) && ((pat_cnt % rd_period) == 0);
        i_beats.wr = (wr_period != 0) && ((pat_cnt % wr_period) == 0);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge i_clk);
        #1;
        pat_cnt++;
        apply_beats();
    endtask

    task automatic wait_running(logic expected);
        int count;
        count = 0;
        while ((o_running !== expected) && (count < 8))
        begin
            step_cycle();
            count++;
        end
        if (o_running !== expected)
        begin
            $display("Timeout: running flag did not become %0b within 8 cycles", expected);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_done(logic expected);
        int count;
        count = 0;
        while ((o_window_done !== expected) && (count < 2 * bw_monitor_pkg::WINDOW_SIZE))
        begin
            step_cycle();
            count++;
        end
        if (o_window_done !== expected)
        begin
            $display("Timeout: window done flag did not become %0b in two windows", expected);
            timed_out = 1'b1;
        end
    endtask

    // ---------------------------------------------------------
    // One table row
    // ---------------------------------------------------------

    task automatic run_row(int idx);
        row_t r;
        int   row_errors;
        r          = rows[idx];
        row_errors = 0;
        // One-cycle command strobe
        i_start         = (r.cmd == CMD_START);
        i_stop          = (r.cmd == CMD_STOP);
        i_counter_reset = (r.cmd == CMD_CLEAR);
        step_cycle();
        i_start         = 1'b0;
        i_stop          = 1'b0;
        i_counter_reset = 1'b0;
        // Previous pattern holds until the running flag has settled
        wait_running(r.exp_running);
        if (timed_out)
            return;
        rd_period = r.rd_period;
        wr_period = r.wr_period;
        apply_beats();
        for (int c = 0; c < r.cycles; c++)
            step_cycle();
        wait_done(r.exp_done);
        if (timed_out)
            return;
        // Let the outputs settle before sampling
        for (int c = 0; c < 8; c++)
            step_cycle();
        if (o_rd_stats !== r.exp_rd)
        begin
            $display("Error: o_rd_stats cur/max/min got %h/%h/%h expected %h/%h/%h",
                     o_rd_stats.cur, o_rd_stats.max, o_rd_stats.min,
                     r.exp_rd.cur, r.exp_rd.max, r.exp_rd.min);
            row_errors++;
        end
        if (o_wr_stats !== r.exp_wr)
        begin
            $display("Error: o_wr_stats cur/max/min got %h/%h/%h expected %h/%h/%h",
                     o_wr_stats.cur, o_wr_stats.max, o_wr_stats.min,
                     r.exp_wr.cur, r.exp_wr.max, r.exp_wr.min);
            row_errors++;
        end
        if (o_running !== r.exp_running)
        begin
            $display("Error: o_running got %h expected %h", o_running, r.exp_running);
            row_errors++;
        end
        if (o_window_done !== r.exp_done)
        begin
            $display("Error: o_window_done got %h expected %h", o_window_done, r.exp_done);
            row_errors++;
        end
        errors += row_errors;
        if (row_errors != 0)
            failed_rows++;
        $display("Test %0d %s: %s", idx, names[idx], (row_errors == 0) ? "ok" : "mismatch");
    endtask

    // ---------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------

    initial
    begin
        i_reset_n       = 1'b0;
        i_start         = 1'b0;
        i_stop          = 1'b0;
        i_counter_reset = 1'b0;
        i_beats         = '0;
        pat_cnt         = 0;
        rd_period       = 0;
        wr_period       = 0;
        errors          = 0;
        failed_rows     = 0;
        timed_out       = 1'b0;
        load_table();
        // Reset held for 3 cycles
        repeat (3) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;
        for (int i = 0; (i < rows.size()) && !timed_out; i++)
            run_row(i);
        $display("Rows: %0d total, %0d failed, %0d check errors, timeout %0b",
                 rows.size(), failed_rows, errors, timed_out);
        if ((errors == 0) && !timed_out)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== bw_monitor_top.f ====
common/bw_monitor_pkg.sv
rtl/bw_control.sv
window/beat_window.sv
rtl/bw_channel.sv
rtl/bw_monitor_top.sv
verif/bw_monitor_sva.sv
verif/bw_monitor_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bandwidth monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module bw_monitor_tb \
    -f bw_monitor_top.f > build.log 2>&1 \
    && ./obj_dir/Vbw_monitor_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

# The log decides the result
grep -q "Simulation FAILED" sim.log && { echo "Test run failed"; exit 1; } || exit 0
